/* Makefile */
SIM         := verilator
TOP         := mem_wb_tb
FILELIST    := files.f
OBJ_DIR     := obj_dir
LOG         := sim.log
PASS_MSG    := TEST PASS
FAIL_MSG    := TEST FAIL
BUILD_FLAGS := --binary --timing --assert -Wno-fatal --top-module $(TOP)
LINT_FLAGS  := --lint-only -Wall --timing --top-module $(TOP)
RUN_FLAGS   := +verilator+error+limit+1000

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(BUILD_FLAGS) -f $(FILELIST) --Mdir $(OBJ_DIR) -o $(TOP)

run: build
	./$(OBJ_DIR)/$(TOP) $(RUN_FLAGS) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation ended without a result"; exit 1; fi

lint:
	$(SIM) $(LINT_FLAGS) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* common/exec_op_if.sv */
// Accepted execute operation
`timescale 1ns/10ps
`default_nettype none

interface exec_op_if;

  // High for exactly the cycle in which the execute handshake completes
  logic                               fire;
  logic                               is_load;
  logic                               is_store;
  logic                               we_rd;
  logic [rv_isa_pkg::REG_AW-1:0]      rd_addr;
  // ALU result, only used when the operation is not a memory access
  logic [rv_isa_pkg::XLEN-1:0]        result;
  // Byte address of a load or store, not yet aligned
  logic [lsu_bus_pkg::ADDR_W-1:0]     addr;
  logic [rv_isa_pkg::WIDTH_W-1:0]     width;
  logic [rv_isa_pkg::XLEN-1:0]        store_data;

  // The top level produces the operation from its execute ports
  modport src (
    output fire, is_load, is_store, we_rd, rd_addr, result, addr, width, store_data
  );

  // The LSU needs the memory fields only
  modport lsu (input fire, is_load, is_store, rd_addr, addr, width, store_data);

  // Writeback takes ALU results straight from the accepted operation
  modport wb (input fire, is_load, is_store, we_rd, rd_addr, result);

endinterface

`default_nettype wire

/* common/lsu_bus_pkg.sv */
// Data bus constants
`default_nettype none

package lsu_bus_pkg;

  // Byte address width on the data bus
  localparam int unsigned ADDR_W = 32;

  // One enable per byte lane of a 32-bit word
  localparam int unsigned BE_W = 4;

  // Byte offset inside a word, the low address bits that the bus drops
  localparam int unsigned OFS_W = 2;

endpackage

`default_nettype wire

/* common/lsu_rsp_if.sv */
// Completed load response
`timescale 1ns/10ps
`default_nettype none

interface lsu_rsp_if;

  // Single-cycle pulse; writeback has no way to stall it
  logic                               valid;
  logic [rv_isa_pkg::REG_AW-1:0]      rd_addr;
  logic [rv_isa_pkg::WIDTH_W-1:0]     width;
  // Byte offset of the load inside the returned word
  logic [lsu_bus_pkg::OFS_W-1:0]      ofs;
  // Raw bus word, still unshifted and unextended
  logic [rv_isa_pkg::XLEN-1:0]        rdata;

  // The LSU returns the load context together with the bus word
  modport lsu (output valid, rd_addr, width, ofs, rdata);

  // Writeback formats the word and writes it to the register file
  modport wb (input valid, rd_addr, width, ofs, rdata);

endinterface

`default_nettype wire

/* common/rv_isa_pkg.sv */
// RV32 ISA constants
`default_nettype none

package rv_isa_pkg;

  // Integer register and data word width
  localparam int unsigned XLEN = 32;

  // Register file geometry, with x0 counted as one of the entries
  localparam int unsigned REG_AW = 5;
  localparam int unsigned NUM_REGS = 32;

  // Load/store width codes follow the funct3 field of the RV32I loads
  localparam int unsigned WIDTH_W = 3;

  // Signed byte, also the store byte code
  localparam logic [WIDTH_W-1:0] LSU_B = 3'b000;

  // Signed halfword, also the store halfword code
  localparam logic [WIDTH_W-1:0] LSU_H = 3'b001;

  // Full word for both loads and stores
  localparam logic [WIDTH_W-1:0] LSU_W = 3'b010;

  // Unsigned byte, only meaningful for loads
  localparam logic [WIDTH_W-1:0] LSU_BU = 3'b100;

  // Unsigned halfword, only meaningful for loads
  localparam logic [WIDTH_W-1:0] LSU_HU = 3'b101;

endpackage

`default_nettype wire

/* dv/mem_wb_props.sv */
// Bus and writeback assertions
`timescale 1ns/10ps
`default_nettype none

module mem_wb_props (
  input wire        clk,
  input wire        rst_n_i,
  input wire        ex_valid_i,
  input wire        ex_ready_o,
  input wire        ex_is_load_i,
  input wire        ex_is_store_i,
  input wire        ex_we_rd_i,
  input wire [4:0]  ex_rd_addr_i,
  input wire [31:0] ex_result_i,
  input wire        dmem_req_valid_o,
  input wire        dmem_req_ready_i,
  input wire        dmem_we_o,
  input wire [31:0] dmem_addr_o,
  input wire [3:0]  dmem_be_o,
  input wire [31:0] dmem_wdata_o,
  input wire [31:0] fwd_data_o
);

  // Failures seen so far, read by the testbench summary
  int unsigned err_cnt = 0;

  // An ALU operation with a destination accepted in this cycle
  logic alu_wr;

  assign alu_wr = ex_valid_i && ex_ready_o && ex_we_rd_i && !ex_is_load_i && !ex_is_store_i;

  // A request the bus has not taken keeps valid and all of its fields
  req_stable_a: assert property (@(posedge clk) disable iff (!rst_n_i)
    dmem_req_valid_o && !dmem_req_ready_i |=> dmem_req_valid_o &&
      $stable({dmem_we_o, dmem_addr_o, dmem_be_o, dmem_wdata_o}))
    else begin
      $error("stalled data-bus request changed");
      err_cnt++;
    end

  // An operation offered while stalled must not start a second access
  no_new_req_a: assert property (@(posedge clk) disable iff (!rst_n_i)
    ex_valid_i && !ex_ready_o |=> !$rose(dmem_req_valid_o))
    else begin
      $error("new data-bus request started while busy");
      err_cnt++;
    end

  // An ALU write aimed at x0 is dropped, so the forward copy keeps its old value
  no_x0_write_a: assert property (@(posedge clk) disable iff (!rst_n_i)
    alu_wr && ex_rd_addr_i == 5'd0 |=> $stable(fwd_data_o))
    else begin
      $error("register write to x0");
      err_cnt++;
    end

  // Forward copy shows an accepted ALU result one cycle later
  fwd_value_a: assert property (@(posedge clk) disable iff (!rst_n_i)
    alu_wr && ex_rd_addr_i != 5'd0 |=> fwd_data_o == $past(ex_result_i))
    else begin
      $error("forward value differs from the last written data");
      err_cnt++;
    end

endmodule

bind mem_wb_top mem_wb_props u_props (.*);

`default_nettype wire

/* dv/mem_wb_tb.sv */
// Memory and writeback testbench
`timescale 1ns/10ps
`default_nettype none

module mem_wb_tb;

  // Operations over all tests: ALU, loads, store/load pairs, random mix
  localparam int N_OPS = 8 + 20 + 14 + 60;
  localparam int MAX_CYCLES = 20 * N_OPS + 200;

  logic        clk, rst_n_i, ex_valid_i, ex_ready_o, ex_is_load_i, ex_is_store_i, ex_we_rd_i;
  logic [4:0]  ex_rd_addr_i, rs1_addr_i, rs2_addr_i;
  logic [2:0]  ex_width_i;
  logic [31:0] ex_result_i, ex_addr_i, ex_store_data_i, rs1_data_o, rs2_data_o, fwd_data_o;
  logic        dmem_req_valid_o, dmem_req_ready_i, dmem_we_o, dmem_rsp_valid_i;
  logic [3:0]  dmem_be_o;
  logic [31:0] dmem_addr_o, dmem_wdata_o, dmem_rdata_i;

  // Bus-side memory, plus the reference copies that expected values come from
  logic [31:0] mem [64];
  logic [31:0] ref_mem [64];
  logic [31:0] ref_regs [32];
  logic [31:0] last_wr, exp_addr, exp_wdata;
  logic [3:0]  exp_be;
  logic        exp_we;
  integer      seed = 32'hddc7fc69;
  integer      bus_seed = 32'hddc7fc69;
  int          cycles, errors, test_start, pass_cnt, fail_cnt;
  string       test_name;

  mem_wb_top DUT (.*);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // Ends the run when operations stop completing
  initial begin
    cycles = 0;
    while (cycles < MAX_CYCLES) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout: no result after %0d clock cycles", MAX_CYCLES);
    $display("TEST FAIL");
    $finish;
  end

  // Width codes 0..4 in the order B, H, W, BU, HU
  function automatic logic [2:0] pick_width(input int n);
    return (n < 3) ? 3'(n) : 3'(n + 1);
  endfunction

  // Low two bits of the code give the size, bit 2 marks an unsigned load
  function automatic logic [3:0] expect_be(input logic [2:0] width, input logic [1:0] ofs);
    logic [3:0] lanes;
    lanes = (width[1:0] == 2'b00) ? 4'b0001 : (width[1:0] == 2'b01) ? 4'b0011 : 4'b1111;
    return lanes << ofs;
  endfunction

  function automatic logic [31:0] expect_load(input logic [2:0] width, input logic [1:0] ofs,
                                              input logic [31:0] word);
    logic [31:0] s;
    s = word >> (8 * ofs);
    case (width[1:0])
      2'b00:   return width[2] ? {24'h0, s[7:0]} : {{24{s[7]}}, s[7:0]};
      2'b01:   return width[2] ? {16'h0, s[15:0]} : {{16{s[15]}}, s[15:0]};
      default: return s;
    endcase
  endfunction

  // Bytes of data where be is set replace those of old
  function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [31:0] data,
                                              input logic [3:0] be);
    logic [31:0] w;
    w = old;
    for (int b = 0; b < 4; b++) begin
      if (be[b]) w[8*b +: 8] = data[8*b +: 8];
    end
    return w;
  endfunction

  function automatic int total_errors();
    return errors + int'(DUT.u_props.err_cnt);
  endfunction

  task automatic check_value(input string what, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else begin
      $display("mismatch %s %s expected %h actual %h", test_name, what, exp, act);
      errors++;
    end
  endtask

  task automatic end_test();
    int n;
    n = total_errors() - test_start;
    if (n == 0) pass_cnt++;
    else fail_cnt++;
    $display("%s finished with %0d errors", test_name, n);
  endtask

  // Data memory model; ready is low about one cycle in three, reads take 1 to 4 cycles
  initial begin
    int delay;
    logic pend;
    logic [31:0] rd_word;
    dmem_req_ready_i = 1'b0;
    dmem_rsp_valid_i = 1'b0;
    dmem_rdata_i = '0;
    pend = 1'b0;
    forever begin
      @(negedge clk);
      dmem_rsp_valid_i = 1'b0;
      if (pend && delay == 0) begin
        dmem_rsp_valid_i = 1'b1;
        dmem_rdata_i = rd_word;
        pend = 1'b0;
      end else if (pend) begin
        delay--;
      end
      dmem_req_ready_i = ($unsigned($random(bus_seed)) % 3) != 0;
      // Valid and ready both high here means the request is taken at the next edge
      if (dmem_req_valid_o && dmem_req_ready_i) begin
        check_value("we", 32'(exp_we), 32'(dmem_we_o));
        check_value("addr", exp_addr, dmem_addr_o);
        check_value("be", 32'(exp_be), 32'(dmem_be_o));
        if (dmem_we_o) begin
          check_value("wdata", merge_bytes('0, exp_wdata, exp_be),
                      merge_bytes('0, dmem_wdata_o, exp_be));
          mem[dmem_addr_o[7:2]] = merge_bytes(mem[dmem_addr_o[7:2]], dmem_wdata_o, dmem_be_o);
        end else begin
          rd_word = mem[dmem_addr_o[7:2]];
          delay = int'($unsigned($random(bus_seed)) % 4);
          pend = 1'b1;
        end
      end
    end
  end

  // One operation through the handshake, then a readback of its destination
  task automatic run_op(input logic ld, input logic st, input logic we, input logic [4:0] rd,
                        input logic [31:0] value, input logic [31:0] addr,
                        input logic [2:0] width);
    exp_we = st;
    exp_addr = {addr[31:2], 2'b00};
    exp_be = expect_be(width, addr[1:0]);
    exp_wdata = value << (8 * addr[1:0]);
    ex_is_load_i = ld;
    ex_is_store_i = st;
    ex_we_rd_i = we;
    ex_rd_addr_i = rd;
    ex_result_i = value;
    ex_store_data_i = value;
    ex_addr_i = addr;
    ex_width_i = width;
    ex_valid_i = 1'b1;
    @(negedge clk);
    // Valid stays up through the stall, and the DUT must not take the operation twice
    while (!ex_ready_o) @(negedge clk);
    ex_valid_i = 1'b0;
    if (st) begin
      ref_mem[addr[7:2]] = merge_bytes(ref_mem[addr[7:2]], exp_wdata, exp_be);
    end else if (rd != 5'd0 && (ld || we)) begin
      ref_regs[rd] = ld ? expect_load(width, addr[1:0], ref_mem[addr[7:2]]) : value;
      last_wr = ref_regs[rd];
    end
    rs1_addr_i = rd;
    rs2_addr_i = rd;
    #5;
    check_value("rs1", ref_regs[rd], rs1_data_o);
    check_value("rs2", ref_regs[rd], rs2_data_o);
    check_value("fwd", last_wr, fwd_data_o);
    @(negedge clk);
  endtask

  initial begin
    logic [31:0] a;
    logic [2:0]  w;
    int          kind;
    {ex_valid_i, ex_is_load_i, ex_is_store_i, ex_we_rd_i} = '0;
    {ex_rd_addr_i, rs1_addr_i, rs2_addr_i, ex_width_i} = '0;
    {ex_result_i, ex_addr_i, ex_store_data_i, last_wr} = '0;
    for (int i = 0; i < 64; i++) begin
      // Hash of the full byte address of each word
      mem[i] = (32'h1000 + 32'(4 * i)) * 32'h9e37_79b1;
      mem[i] = mem[i] ^ (mem[i] >> 15);
      ref_mem[i] = mem[i];
    end
    for (int r = 0; r < 32; r++) begin
      ref_regs[r] = '0;
    end
    rst_n_i = 1'b0;
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst_n_i = 1'b1;

    test_name = "reset_state";
    test_start = total_errors();
    for (int r = 0; r < 16; r++) begin
      rs1_addr_i = 5'(r);
      rs2_addr_i = 5'(r + 16);
      #5;
      check_value("ex_ready", 32'd1, 32'(ex_ready_o));
      check_value("req_valid", 32'd0, 32'(dmem_req_valid_o));
      check_value("rs1", 32'd0, rs1_data_o);
      check_value("rs2", 32'd0, rs2_data_o);
      @(negedge clk);
    end
    end_test();

    test_name = "alu_write";
    test_start = total_errors();
    for (int k = 0; k < 6; k++) begin
      run_op(1'b0, 1'b0, 1'b1, 5'(5 * k + 3), $random(seed), '0, rv_isa_pkg::LSU_W);
    end
    // A write to x0 and an operation without we_rd must both leave the file untouched
    run_op(1'b0, 1'b0, 1'b1, 5'd0, 32'hffff_ffff, '0, rv_isa_pkg::LSU_W);
    run_op(1'b0, 1'b0, 1'b0, 5'd3, 32'h1234_5678, '0, rv_isa_pkg::LSU_W);
    end_test();

    test_name = "load_widths";
    test_start = total_errors();
    for (int k = 0; k < 20; k++) begin
      run_op(1'b1, 1'b0, 1'b1, 5'($unsigned($random(seed)) % 31 + 1), $random(seed),
             32'h1000 + 32'(4 * k + k % 4), pick_width(k / 4));
    end
    end_test();

    test_name = "store_merge";
    test_start = total_errors();
    for (int k = 0; k < 7; k++) begin
      // Bytes at all four offsets, both halfwords, then a full word
      w = (k < 4) ? rv_isa_pkg::LSU_B : (k < 6) ? rv_isa_pkg::LSU_H : rv_isa_pkg::LSU_W;
      a = 32'h1080 + 32'(4 * k + ((k < 4) ? k : (k == 5) ? 2 : 0));
      run_op(1'b0, 1'b1, 1'b0, 5'd9, $random(seed), a, w);
      // The aligned word load returns every lane of the merged word
      run_op(1'b1, 1'b0, 1'b1, 5'(k + 20), $random(seed), {a[31:2], 2'b00},
             rv_isa_pkg::LSU_W);
    end
    end_test();

    test_name = "random_mix";
    test_start = total_errors();
    for (int n = 0; n < 60; n++) begin
      kind = int'($unsigned($random(seed)) % 3);
      w = pick_width(int'($unsigned($random(seed)) % 5));
      a = 32'h1000 + ($unsigned($random(seed)) % 64);
      // Stores use the signed codes and natural alignment
      if (kind == 2) begin
        w[2] = 1'b0;
        if (w[1:0] != 2'b00) a[0] = 1'b0;
        if (w[1:0] == 2'b10) a[1] = 1'b0;
      end
      run_op(kind == 1, kind == 2, (kind == 1) | 1'($random(seed)),
             5'($unsigned($random(seed)) % 32), $random(seed), a, w);
    end
    end_test();

    $display("summary: %0d tests passed, %0d tests failed", pass_cnt, fail_cnt);
    if (fail_cnt == 0 && total_errors() == 0) $display("TEST PASS");
    else $display("TEST FAIL");
    $finish;
  end

endmodule

`default_nettype wire

/* files.f */
common/rv_isa_pkg.sv
common/lsu_bus_pkg.sv
common/exec_op_if.sv
common/lsu_rsp_if.sv
hdl/lsu/lsu.sv
hdl/wb.sv
hdl/regfile.sv
hdl/mem_wb_top.sv
dv/mem_wb_props.sv
dv/mem_wb_tb.sv

/* hdl/lsu/lsu.sv */
// Load/store unit
`timescale 1ns/10ps
`default_nettype none

module lsu (
  input  wire                                   clk,
  input  wire                                   rst_n_i,
  exec_op_if.lsu                                op,
  lsu_rsp_if.lsu                                rsp,
  output logic                                  busy_o,
  output logic                                  dmem_req_valid_o,
  input  wire                                   dmem_req_ready_i,
  output logic                                  dmem_we_o,
  output logic [lsu_bus_pkg::ADDR_W-1:0]        dmem_addr_o,
  output logic [lsu_bus_pkg::BE_W-1:0]          dmem_be_o,
  output logic [rv_isa_pkg::XLEN-1:0]           dmem_wdata_o,
  input  wire                                   dmem_rsp_valid_i,
  input  wire  [rv_isa_pkg::XLEN-1:0]           dmem_rdata_i
);

  // Request valid stays up from acceptance until the bus takes the request
  logic                                 req_valid_q;
  // Set for loads from acceptance until the read data comes back
  logic                                 rsp_pend_q;
  logic                                 mem_fire;
  logic [lsu_bus_pkg::OFS_W-1:0]        ofs;

  // Request payload, held steady while the bus stalls
  logic                                 req_we_q;
  logic [lsu_bus_pkg::ADDR_W-1:0]       req_addr_q;
  logic [lsu_bus_pkg::BE_W-1:0]         req_be_q;
  logic [rv_isa_pkg::XLEN-1:0]          req_wdata_q;

  // Load context that travels back with the response word
  logic [rv_isa_pkg::REG_AW-1:0]        ld_rd_q;
  logic [rv_isa_pkg::WIDTH_W-1:0]       ld_width_q;
  logic [lsu_bus_pkg::OFS_W-1:0]        ld_ofs_q;

  // Byte enables of the access, moved to the lane selected by the offset
  function automatic logic [lsu_bus_pkg::BE_W-1:0] lane_be(
    input logic [rv_isa_pkg::WIDTH_W-1:0] width,
    input logic [lsu_bus_pkg::OFS_W-1:0]  lane
  );
    logic [lsu_bus_pkg::BE_W-1:0] base;
    case (width)
      rv_isa_pkg::LSU_B, rv_isa_pkg::LSU_BU: base = lsu_bus_pkg::BE_W'(4'b0001);
      rv_isa_pkg::LSU_H, rv_isa_pkg::LSU_HU: base = lsu_bus_pkg::BE_W'(4'b0011);
      rv_isa_pkg::LSU_W:                     base = '1;
      default:                               base = '1;
    endcase
    return base << lane;
  endfunction

  // Only memory operations start a bus access
  assign mem_fire = op.fire & (op.is_load | op.is_store);
  assign ofs      = op.addr[lsu_bus_pkg::OFS_W-1:0];

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      req_valid_q <= 1'b0;
      rsp_pend_q  <= 1'b0;
    end else begin
      // The execute port is stalled while busy, so a new access never overlaps
      if (mem_fire) begin
        req_valid_q <= 1'b1;
      end else if (req_valid_q && dmem_req_ready_i) begin
        req_valid_q <= 1'b0;
      end
      if (mem_fire && op.is_load) begin
        rsp_pend_q <= 1'b1;
      end else if (dmem_rsp_valid_i) begin
        rsp_pend_q <= 1'b0;
      end
    end
  end

  // Capture the request at acceptance
  always_ff @(posedge clk) begin
    if (mem_fire) begin
      req_we_q    <= op.is_store;
      // The bus sees word addresses only and the offset moves into the byte lanes
      req_addr_q  <= {op.addr[lsu_bus_pkg::ADDR_W-1:lsu_bus_pkg::OFS_W],
                      {lsu_bus_pkg::OFS_W{1'b0}}};
      req_be_q    <= lane_be(op.width, ofs);
      req_wdata_q <= op.store_data << {ofs, 3'b000};
      ld_rd_q     <= op.rd_addr;
      ld_width_q  <= op.width;
      ld_ofs_q    <= ofs;
    end
  end

  // Stores finish at the handshake, loads at the response
  assign busy_o = req_valid_q | rsp_pend_q;

  assign dmem_req_valid_o = req_valid_q;
  assign dmem_we_o        = req_we_q;
  assign dmem_addr_o      = req_addr_q;
  assign dmem_be_o        = req_be_q;
  assign dmem_wdata_o     = req_wdata_q;

  // The response passes through in the same cycle so the write lands on its edge
  assign rsp.valid   = dmem_rsp_valid_i & rsp_pend_q;
  assign rsp.rd_addr = ld_rd_q;
  assign rsp.width   = ld_width_q;
  assign rsp.ofs     = ld_ofs_q;
  assign rsp.rdata   = dmem_rdata_i;

endmodule

`default_nettype wire

/* hdl/mem_wb_top.sv */
// Memory and writeback top level
`timescale 1ns/10ps
`default_nettype none

module mem_wb_top (
  input  wire                                   clk,
  input  wire                                   rst_n_i,
  // Execute handshake and operation fields
  input  wire                                   ex_valid_i,
  output logic                                  ex_ready_o,
  input  wire                                   ex_is_load_i,
  input  wire                                   ex_is_store_i,
  input  wire                                   ex_we_rd_i,
  input  wire  [rv_isa_pkg::REG_AW-1:0]         ex_rd_addr_i,
  input  wire  [rv_isa_pkg::XLEN-1:0]           ex_result_i,
  input  wire  [lsu_bus_pkg::ADDR_W-1:0]        ex_addr_i,
  input  wire  [rv_isa_pkg::WIDTH_W-1:0]        ex_width_i,
  input  wire  [rv_isa_pkg::XLEN-1:0]           ex_store_data_i,
  // Data bus request
  output logic                                  dmem_req_valid_o,
  input  wire                                   dmem_req_ready_i,
  output logic                                  dmem_we_o,
  output logic [lsu_bus_pkg::ADDR_W-1:0]        dmem_addr_o,
  output logic [lsu_bus_pkg::BE_W-1:0]          dmem_be_o,
  output logic [rv_isa_pkg::XLEN-1:0]           dmem_wdata_o,
  // Data bus read response
  input  wire                                   dmem_rsp_valid_i,
  input  wire  [rv_isa_pkg::XLEN-1:0]           dmem_rdata_i,
  // Read ports standing in for decode
  input  wire  [rv_isa_pkg::REG_AW-1:0]         rs1_addr_i,
  input  wire  [rv_isa_pkg::REG_AW-1:0]         rs2_addr_i,
  output logic [rv_isa_pkg::XLEN-1:0]           rs1_data_o,
  output logic [rv_isa_pkg::XLEN-1:0]           rs2_data_o,
  output logic [rv_isa_pkg::XLEN-1:0]           fwd_data_o
);

  logic                                 lsu_busy;
  logic                                 rf_we;
  logic [rv_isa_pkg::REG_AW-1:0]        rf_waddr;
  logic [rv_isa_pkg::XLEN-1:0]          rf_wdata;

  exec_op_if u_op ();
  lsu_rsp_if u_rsp ();

  // The execute port stalls for the whole memory access
  assign ex_ready_o = ~lsu_busy;

  assign u_op.fire       = ex_valid_i & ex_ready_o;
  assign u_op.is_load    = ex_is_load_i;
  assign u_op.is_store   = ex_is_store_i;
  assign u_op.we_rd      = ex_we_rd_i;
  assign u_op.rd_addr    = ex_rd_addr_i;
  assign u_op.result     = ex_result_i;
  assign u_op.addr       = ex_addr_i;
  assign u_op.width      = ex_width_i;
  assign u_op.store_data = ex_store_data_i;

  lsu u_lsu (
    .clk              (clk),
    .rst_n_i          (rst_n_i),
    .op               (u_op.lsu),
    .rsp              (u_rsp.lsu),
    .busy_o           (lsu_busy),
    .dmem_req_valid_o (dmem_req_valid_o),
    .dmem_req_ready_i (dmem_req_ready_i),
    .dmem_we_o        (dmem_we_o),
    .dmem_addr_o      (dmem_addr_o),
    .dmem_be_o        (dmem_be_o),
    .dmem_wdata_o     (dmem_wdata_o),
    .dmem_rsp_valid_i (dmem_rsp_valid_i),
    .dmem_rdata_i     (dmem_rdata_i)
  );

  wb u_wb (
    .clk        (clk),
    .rst_n_i    (rst_n_i),
    .op         (u_op.wb),
    .rsp        (u_rsp.wb),
    .rf_we_o    (rf_we),
    .rf_waddr_o (rf_waddr),
    .rf_wdata_o (rf_wdata),
    .fwd_data_o (fwd_data_o)
  );

  regfile u_regfile (
    .clk      (clk),
    .rst_n_i  (rst_n_i),
    .we_i     (rf_we),
    .waddr_i  (rf_waddr),
    .wdata_i  (rf_wdata),
    .raddr1_i (rs1_addr_i),
    .raddr2_i (rs2_addr_i),
    .rdata1_o (rs1_data_o),
    .rdata2_o (rs2_data_o)
  );

endmodule

`default_nettype wire

/* hdl/regfile.sv */
// Integer register file
`timescale 1ns/10ps
`default_nettype none

module regfile (
  input  wire                                   clk,
  input  wire                                   rst_n_i,
  input  wire                                   we_i,
  input  wire  [rv_isa_pkg::REG_AW-1:0]         waddr_i,
  input  wire  [rv_isa_pkg::XLEN-1:0]           wdata_i,
  input  wire  [rv_isa_pkg::REG_AW-1:0]         raddr1_i,
  input  wire  [rv_isa_pkg::REG_AW-1:0]         raddr2_i,
  output logic [rv_isa_pkg::XLEN-1:0]           rdata1_o,
  output logic [rv_isa_pkg::XLEN-1:0]           rdata2_o
);

  logic [rv_isa_pkg::XLEN-1:0] regs_q [rv_isa_pkg::NUM_REGS];

  // All entries start at zero after reset
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      for (int i = 0; i < rv_isa_pkg::NUM_REGS; i++) begin
        regs_q[i] <= '0;
      end
    end else if (we_i && (waddr_i != '0)) begin
      regs_q[waddr_i] <= wdata_i;
    end
  end

  // Asynchronous reads, x0 forced to zero
  assign rdata1_o = (raddr1_i == '0) ? '0 : regs_q[raddr1_i];
  assign rdata2_o = (raddr2_i == '0) ? '0 : regs_q[raddr2_i];

endmodule

`default_nettype wire

/* hdl/wb.sv */
// Writeback select and forwarding
`timescale 1ns/10ps
`default_nettype none

module wb (
  input  wire                                   clk,
  input  wire                                   rst_n_i,
  exec_op_if.wb                                 op,
  lsu_rsp_if.wb                                 rsp,
  output logic                                  rf_we_o,
  output logic [rv_isa_pkg::REG_AW-1:0]         rf_waddr_o,
  output logic [rv_isa_pkg::XLEN-1:0]           rf_wdata_o,
  output logic [rv_isa_pkg::XLEN-1:0]           fwd_data_o
);

  logic                                 alu_we;
  logic                                 wr_req;
  // Copy of the last value written, offered for forwarding
  logic [rv_isa_pkg::XLEN-1:0]          bkp_q;

  // Move the addressed byte or halfword down to bit 0 and extend it
  function automatic logic [rv_isa_pkg::XLEN-1:0] fmt_load(
    input logic [rv_isa_pkg::WIDTH_W-1:0] width,
    input logic [lsu_bus_pkg::OFS_W-1:0]  ofs,
    input logic [rv_isa_pkg::XLEN-1:0]    rdata
  );
    logic [rv_isa_pkg::XLEN-1:0] data;
    data = rdata >> {ofs, 3'b000};
    case (width)
      rv_isa_pkg::LSU_B:  return {{(rv_isa_pkg::XLEN-8){data[7]}}, data[7:0]};
      rv_isa_pkg::LSU_H:  return {{(rv_isa_pkg::XLEN-16){data[15]}}, data[15:0]};
      rv_isa_pkg::LSU_BU: return {{(rv_isa_pkg::XLEN-8){1'b0}}, data[7:0]};
      rv_isa_pkg::LSU_HU: return {{(rv_isa_pkg::XLEN-16){1'b0}}, data[15:0]};
      rv_isa_pkg::LSU_W:  return data;
      default:            return data;
    endcase
  endfunction

  // ALU results write at acceptance; memory operations write later, if at all
  assign alu_we = op.fire & op.we_rd & ~op.is_load & ~op.is_store;

  always_comb begin
    wr_req     = alu_we;
    rf_waddr_o = op.rd_addr;
    rf_wdata_o = op.result;
    // A load response only arrives while the execute port is stalled,
    // so it can never meet an ALU write in the same cycle
    if (rsp.valid) begin
      wr_req     = 1'b1;
      rf_waddr_o = rsp.rd_addr;
      rf_wdata_o = fmt_load(rsp.width, rsp.ofs, rsp.rdata);
    end
    // Writes to x0 are discarded here so they never disturb the backup copy
    rf_we_o = wr_req & (rf_waddr_o != '0);
  end

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      bkp_q <= '0;
    end else if (rf_we_o) begin
      bkp_q <= rf_wdata_o;
    end
  end

  // Visible one cycle after the write, same as the register file
  assign fwd_data_o = bkp_q;

endmodule

`default_nettype wire
